/* Makefile */
VERILATOR ?= verilator
TOP       ?= tagePredictorTb
FLIST     ?= flist.f
VFLAGS    ?= --timing
SEED_ARGS ?= +verilator+seed+38
OBJDIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(OBJDIR)

/* bimodalTable.sv */
`timescale 1ns/10ps

module bimodalTable #(
    parameter int baseBits = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  tagePkg::pcT readPc,
    input  logic        writeEn,
    input  tagePkg::pcT writePc,
    input  logic        writeTaken,
    output logic        readTaken
);
    localparam int depth = 2 ** baseBits;

    logic [1:0]          counters [depth];
    logic [baseBits-1:0] readIdx;
    logic [baseBits-1:0] writeIdx;
    logic [1:0]          cur;

    assign readIdx   = readPc[baseBits+1:2];
    assign writeIdx  = writePc[baseBits+1:2];
    assign cur       = counters[writeIdx];
    assign readTaken = counters[readIdx][1];   // Counter MSB.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                counters[i] <= 2'b01;   // Weakly not-taken.
            end
        end else if (writeEn) begin
            if (writeTaken && cur != 2'b11) begin
                counters[writeIdx] <= cur + 2'b01;
            end else if (!writeTaken && cur != 2'b00) begin
                counters[writeIdx] <= cur - 2'b01;
            end
        end
    end

endmodule

/* flist.f */
+incdir+.
tagePkg.sv
historyHash.sv
bimodalTable.sv
tageTable.sv
tagePredictor.sv
tagePredictorTb.sv

/* historyHash.sv */
`timescale 1ns/10ps

module historyHash #(
    parameter int histLen = 4
) (
    input  tagePkg::pcT    pc,
    input  tagePkg::ghistT ghist,
    output tagePkg::idxT   index,
    output tagePkg::tagT   tag
);
    import tagePkg::*;

    idxT idxFold;
    tagT tagFold;

    // --------------------
    // Chunked XOR fold of the truncated history.
    always_comb begin
        idxFold = '0;
        tagFold = '0;
        for (int i = 0; i < histLen; i++) begin
            idxFold[i % idxBits] = idxFold[i % idxBits] ^ ghist[i];
            tagFold[i % tagBits] = tagFold[i % tagBits] ^ ghist[i];
        end
    end

    assign index = pc[idxBits+1:2] ^ idxFold;             // pc[7:2].
    assign tag   = pc[pcBits-1:pcBits-tagBits] ^ tagFold;  // pc[15:8].

endmodule

/* tagePkg.sv */
package tagePkg;

    // --------------------
    // Widths and geometry.
    localparam int pcBits    = 16;
    localparam int ghistBits = 16;
    localparam int idxBits   = 6;   // 64 entries per tagged table.
    localparam int tagBits   = 8;
    localparam int numTagged = 3;
    localparam int histLen1  = 4;
    localparam int histLen2  = 8;
    localparam int histLen3  = 16;

    typedef logic [pcBits-1:0]    pcT;
    typedef logic [ghistBits-1:0] ghistT;   // Newest outcome in bit 0.
    typedef logic [idxBits-1:0]   idxT;
    typedef logic [tagBits-1:0]   tagT;

    typedef enum logic [1:0] {provBase, provT1, provT2, provT3} providerE;

    typedef struct packed {
        logic     taken;
        providerE provider;
    } predResultT;

    typedef struct packed {
        pcT       pc;
        logic     taken;       // Resolved outcome.
        logic     predTaken;
        providerE provider;
    } updateReqT;

    typedef struct packed {
        idxT  addr;
        tagT  tag;
        logic valid;
        logic update;   // Train this entry.
        logic isNew;    // Allocation candidate.
        logic taken;
        logic useful;   // Up or down.
    } tableWriteT;

    typedef enum logic [1:0] {updIdle, updWrite, updDecay, updAck} updStateE;

endpackage

/* tagePredictor.sv */
`timescale 1ns/10ps

module tagePredictor #(
    parameter int baseBits   = 8,
    parameter int cntBits    = 2,
    parameter int usefulBits = 2,
    parameter int decayBits  = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                predReq,
    input  tagePkg::pcT         predPc,
    output logic                predAck,
    output tagePkg::predResultT predResult,
    input  logic                updReq,
    input  tagePkg::updateReqT  upd,
    output logic                updAck
);
    import tagePkg::*;

    updStateE             updState;
    ghistT                ghist;
    logic [decayBits-1:0] decayCnt;

    pcT                         hashPc;
    idxT  [numTagged-1:0]       tIndex;
    tagT  [numTagged-1:0]       tTag;
    logic [numTagged-1:0]       tHit;
    logic [numTagged-1:0]       tTaken;
    logic [numTagged-1:0]       allocOk;
    tableWriteT [numTagged-1:0] wr;
    logic                       anyAlloc;
    logic                       baseTaken;
    logic                       writing;
    logic                       mispredict;
    logic                       predStart;
    predResultT                 predNext;

    assign writing    = updState == updWrite;
    assign hashPc     = writing ? upd.pc : predPc;
    assign mispredict = upd.predTaken != upd.taken;
    assign anyAlloc   = |allocOk;
    assign predStart  = predReq && !predAck && updState == updIdle && !updReq;

    // --------------------
    // Tables.
    bimodalTable #(
        .baseBits(baseBits)
    ) base (
        .clk       (clk),
        .rst       (rst),
        .readPc    (predPc),
        .writeEn   (writing && upd.provider == provBase),
        .writePc   (upd.pc),
        .writeTaken(upd.taken),
        .readTaken (baseTaken)
    );

    for (genvar g = 0; g < numTagged; g++) begin : gTagged
        historyHash #(
            .histLen(g == 0 ? histLen1 : (g == 1 ? histLen2 : histLen3))
        ) hash (
            .pc   (hashPc),
            .ghist(ghist),
            .index(tIndex[g]),
            .tag  (tTag[g])
        );

        // Table g serves provider g + 1.
        assign wr[g] = '{
            addr:   tIndex[g],
            tag:    tTag[g],
            valid:  writing,
            update: upd.provider == providerE'(g + 1),
            isNew:  mispredict && upd.provider < providerE'(g + 1),
            taken:  upd.taken,
            useful: !mispredict
        };

        tageTable #(
            .cntBits   (cntBits),
            .usefulBits(usefulBits)
        ) table0 (
            .clk        (clk),
            .rst        (rst),
            .readAddr   (tIndex[g]),
            .readTag    (tTag[g]),
            .wr         (wr[g]),
            .anyAlloc   (anyAlloc),
            .decay      (updState == updDecay),
            .readHit    (tHit[g]),
            .readTaken  (tTaken[g]),
            .readCounter(),
            .allocOk    (allocOk[g])
        );
    end

    // Longest matching table wins.
    always_comb begin
        predNext.provider = provBase;
        predNext.taken    = baseTaken;
        for (int i = 0; i < numTagged; i++) begin
            if (tHit[i]) begin
                predNext.provider = providerE'(i + 1);
                predNext.taken    = tTaken[i];
            end
        end
    end

    // --------------------
    // Prediction handshake.
    always_ff @(posedge clk) begin
        if (rst) begin
            predAck <= 1'b0;
        end else if (predStart) begin
            predAck <= 1'b1;
        end else if (predAck && !predReq) begin
            predAck <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (predStart) begin
            predResult <= predNext;
        end
    end

    // --------------------
    // Update FSM.
    always_ff @(posedge clk) begin
        if (rst) begin
            updState <= updIdle;
            updAck   <= 1'b0;
            ghist    <= '0;
            decayCnt <= '0;
        end else begin
            updAck <= updState == tagePkg::updAck && updReq;
            case (updState)
                updIdle: begin
                    if (updReq && !updAck) begin
                        updState <= updWrite;
                    end
                end
                updWrite: begin
                    ghist    <= {ghist[ghistBits-2:0], upd.taken};
                    decayCnt <= decayCnt + 1'b1;
                    updState <= (decayCnt == '1) ? updDecay : tagePkg::updAck;
                end
                updDecay: updState <= tagePkg::updAck;   // Aging pulse.
                tagePkg::updAck: begin
                    if (!updReq) begin
                        updState <= updIdle;
                    end
                end
                default: updState <= updIdle;
            endcase
        end
    end

endmodule

/* tageModel.svh */
`ifndef TAGE_MODEL_SVH
`define TAGE_MODEL_SVH

int    refBase   [2**baseBits];
int    refTag    [numTagged][2**idxBits];
int    refCnt    [numTagged][2**idxBits];
int    refUseful [numTagged][2**idxBits];
ghistT refHist;
int    refUpdCount;

function automatic int satStep(input int v, input logic up, input int maxVal);
    if (up)
        return (v < maxVal) ? v + 1 : v;
    return (v > 0) ? v - 1 : v;
endfunction

// Truncate to len bits, then XOR width-sized chunks from bit 0 up.
function automatic int foldHist(input int len, input int width);
    int trunc;
    int acc;
    trunc = int'(refHist) & ((1 << len) - 1);
    acc   = 0;
    for (int c = 0; c < len; c += width)
        acc = acc ^ ((trunc >> c) & ((1 << width) - 1));
    return acc;
endfunction

function automatic int histLenOf(input int t);
    return (t == 0) ? histLen1 : ((t == 1) ? histLen2 : histLen3);
endfunction

function automatic int refIndex(input pcT pc, input int t);
    return int'(pc[7:2]) ^ foldHist(histLenOf(t), idxBits);
endfunction

function automatic int refTagOf(input pcT pc, input int t);
    return int'(pc[15:8]) ^ foldHist(histLenOf(t), tagBits);
endfunction

task automatic resetRef();
    foreach (refBase[i])
        refBase[i] = 1;   // Weakly not-taken.
    foreach (refTag[t, i]) begin
        refTag[t][i]    = 0;
        refCnt[t][i]    = 0;
        refUseful[t][i] = 0;
    end
    refHist     = '0;
    refUpdCount = 0;
endtask

function automatic predResultT predictRef(input pcT pc);
    predResultT res;
    int         ix;
    res.taken    = refBase[int'(pc[baseBits+1:2])] >= 2;
    res.provider = provBase;
    for (int t = 0; t < numTagged; t++) begin
        ix = refIndex(pc, t);
        if (refTag[t][ix] == refTagOf(pc, t)) begin
            res.provider = providerE'(t + 1);
            res.taken    = refCnt[t][ix] >= (1 << (cntBits - 1));   // Counter MSB.
        end
    end
    return res;
endfunction

task automatic updateRef(input updateReqT u);
    int   ix [numTagged];
    int   bi;
    int   prov;
    logic mis;
    logic allocated;
    bi        = int'(u.pc[baseBits+1:2]);
    prov      = int'(u.provider);
    mis       = u.predTaken != u.taken;
    allocated = 1'b0;
    for (int t = 0; t < numTagged; t++)
        ix[t] = refIndex(u.pc, t);
    if (prov == 0) begin
        refBase[bi] = satStep(refBase[bi], u.taken, 3);
    end else begin
        refCnt[prov-1][ix[prov-1]] = satStep(refCnt[prov-1][ix[prov-1]], u.taken,
                                             (1 << cntBits) - 1);
        refUseful[prov-1][ix[prov-1]] = satStep(refUseful[prov-1][ix[prov-1]], !mis,
                                                (1 << usefulBits) - 1);
    end
    // Tables longer than the provider are candidates.
    if (mis) begin
        for (int t = prov; t < numTagged; t++) begin
            if (refUseful[t][ix[t]] == 0) begin
                refTag[t][ix[t]] = refTagOf(u.pc, t);
                refCnt[t][ix[t]] = u.taken ? (1 << (cntBits - 1)) : 0;
                allocated        = 1'b1;
            end
        end
        if (!allocated)
            for (int t = prov; t < numTagged; t++)
                refUseful[t][ix[t]] = satStep(refUseful[t][ix[t]], 1'b0, 0);
    end
    refHist     = {refHist[ghistBits-2:0], u.taken};
    refUpdCount = (refUpdCount + 1) % (1 << decayBits);
    if (refUpdCount == 0)
        foreach (refUseful[t, i])
            refUseful[t][i] = satStep(refUseful[t][i], 1'b0, 0);   // Ageing.
endtask

`endif

/* tagePredictorTb.sv */
`timescale 1ns/10ps

module tagePredictorTb;
    import tagePkg::*;

    localparam int baseBits      = 8;
    localparam int cntBits       = 2;
    localparam int usefulBits    = 2;
    localparam int decayBits     = 3;
    localparam int timeoutCycles = 20;

    localparam predResultT baseNotTaken = '{taken: 1'b0, provider: provBase};
    localparam predResultT baseTaken    = '{taken: 1'b1, provider: provBase};
    localparam predResultT t3Taken      = '{taken: 1'b1, provider: provT3};

    logic       clk;
    logic       rst;
    logic       predReq;
    pcT         predPc;
    logic       predAck;
    predResultT predResult;
    logic       updReq;
    updateReqT  upd;
    logic       updAck;
    integer     seed;
    pcT         pcSet [8];
    predResultT got;

    `include "tageModel.svh"

    tagePredictor #(.baseBits(baseBits), .cntBits(cntBits), .usefulBits(usefulBits),
                    .decayBits(decayBits)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abortRun(input string msg);
        $display("Test failures found");
        $fatal(1, "%s", msg);
    endtask

    task automatic checkPred(input string name, input predResultT exp, input predResultT act);
        if (act !== exp) begin
            $display("FAIL %s: expected taken=%0b provider=%s, actual taken=%0b provider=%s",
                     name, exp.taken, exp.provider.name(), act.taken, act.provider.name());
            abortRun("prediction mismatch");
        end
    endtask

    task automatic checkAck(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected %0b, actual %0b", name, exp, act);
            abortRun("handshake level mismatch");
        end
    endtask

    task automatic waitAck(input bit onUpd, input logic level, input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > timeoutCycles)
                abortRun({"timed out waiting for ", what});
        end while ((onUpd ? updAck : predAck) !== level);
    endtask

    // --------------------
    // Handshake drivers.
    task automatic doPredict(input string name, input pcT pc, output predResultT res);
        predResultT exp;
        exp = predictRef(pc);
        checkAck({name, " predAck idle"}, 1'b0, predAck);
        predPc  = pc;
        predReq = 1'b1;
        waitAck(1'b0, 1'b1, "predAck to rise");
        res = predResult;
        @(negedge clk);   // Req still high, ack must stay up.
        checkAck({name, " predAck held"}, 1'b1, predAck);
        predReq = 1'b0;
        waitAck(1'b0, 1'b0, "predAck to fall");
        checkPred(name, exp, res);
    endtask

    task automatic doUpdate(input string name, input pcT pc, input logic outcome,
                            input predResultT pred);
        checkAck({name, " updAck idle"}, 1'b0, updAck);
        upd    = '{pc: pc, taken: outcome, predTaken: pred.taken, provider: pred.provider};
        updReq = 1'b1;
        waitAck(1'b1, 1'b1, "updAck to rise");
        @(negedge clk);
        checkAck({name, " updAck held"}, 1'b1, updAck);
        updReq = 1'b0;
        waitAck(1'b1, 1'b0, "updAck to fall");
        updateRef(upd);
    endtask

    // --------------------
    initial begin
        logic [31:0] r;
        pcT          pc;
        seed    = 38;
        rst     = 1'b1;
        predReq = 1'b0;
        predPc  = '0;
        updReq  = 1'b0;
        upd     = '0;
        pcSet   = '{16'h1234, 16'h2468, 16'h7310, 16'h0C40,
                    16'h5678, 16'hA0F0, 16'h3BC8, 16'hE004};
        resetRef();
        repeat (3) @(negedge clk);
        rst = 1'b0;

        checkAck("predAck after reset", 1'b0, predAck);
        checkAck("updAck after reset", 1'b0, updAck);
        for (int i = 0; i < 4; i++) begin
            doPredict("reset predict", pcSet[i], got);
            checkPred("reset predict", baseNotTaken, got);
        end

        for (int i = 0; i < 2; i++) begin
            doPredict("base train", 16'h2468, got);
            doUpdate("base train", 16'h2468, 1'b1, got);
        end
        doPredict("base trained", 16'h2468, got);
        checkPred("base trained", baseTaken, got);

        // All-ones history stays put on a taken outcome.
        for (int i = 0; i < 16; i++) begin
            doPredict("history fill", 16'h2468, got);
            doUpdate("history fill", 16'h2468, 1'b1, got);
        end
        doPredict("alloc before", 16'h7310, got);
        checkPred("alloc before", baseNotTaken, got);
        doUpdate("alloc", 16'h7310, 1'b1, got);
        doPredict("alloc after", 16'h7310, got);
        checkPred("alloc after", t3Taken, got);

        for (int i = 0; i < 300; i++) begin
            r  = $random(seed);
            pc = pcSet[r[4:2]];
            doPredict($sformatf("random %0d", i), pc, got);
            doUpdate($sformatf("random %0d", i), pc, r[0] ? got.taken : r[1], got);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

/* tageTable.sv */
`timescale 1ns/10ps

module tageTable #(
    parameter int cntBits    = 2,
    parameter int usefulBits = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  tagePkg::idxT        readAddr,
    input  tagePkg::tagT        readTag,
    input  tagePkg::tableWriteT wr,
    input  logic                anyAlloc,
    input  logic                decay,
    output logic                readHit,
    output logic                readTaken,
    output logic [cntBits-1:0]  readCounter,
    output logic                allocOk
);
    import tagePkg::*;

    localparam int numEntries = 2 ** idxBits;

    typedef struct packed {
        tagT                   tag;
        logic [usefulBits-1:0] useful;
        logic [cntBits-1:0]    counter;
    } entryT;

    entryT mem [numEntries];
    entryT cur;   // Entry under the write port.

    assign cur = mem[wr.addr];

    // --------------------
    // Read side.
    assign readHit     = mem[readAddr].tag == readTag;
    assign readCounter = mem[readAddr].counter;
    assign readTaken   = readCounter[cntBits-1];

    // Free slot for a misprediction.
    assign allocOk = wr.valid && !wr.update && wr.isNew && cur.useful == '0;

    // --------------------
    // Write side.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numEntries; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (decay) begin
                for (int i = 0; i < numEntries; i++) begin
                    if (mem[i].useful != '0) begin
                        mem[i].useful <= mem[i].useful - 1'b1;
                    end
                end
            end
            if (wr.valid) begin
                if (wr.update) begin
                    if (wr.taken && cur.counter != '1) begin
                        mem[wr.addr].counter <= cur.counter + 1'b1;
                    end else if (!wr.taken && cur.counter != '0) begin
                        mem[wr.addr].counter <= cur.counter - 1'b1;
                    end
                    if (wr.useful && cur.useful != '1) begin
                        mem[wr.addr].useful <= cur.useful + 1'b1;
                    end else if (!wr.useful && cur.useful != '0) begin
                        mem[wr.addr].useful <= cur.useful - 1'b1;
                    end
                end else if (wr.isNew) begin
                    if (cur.useful == '0) begin
                        mem[wr.addr].tag     <= wr.tag;
                        mem[wr.addr].counter <= {wr.taken, {(cntBits-1){1'b0}}};
                        mem[wr.addr].useful  <= '0;
                    end else if (!anyAlloc) begin
                        mem[wr.addr].useful <= cur.useful - 1'b1;   // Nobody allocated.
                    end
                end
            end
        end
    end

endmodule
